/* design/replay_trace_pkg.sv */
`default_nettype none

package replay_trace_pkg;

    // bus word width from the trace memory
    localparam int AXI_WIDTH = 64;

    // unit lengths and offsets are multiples of this many bits
    localparam int PACKET_ALIGNMENT = 8;
    localparam int ALIGN_BITS = $clog2(PACKET_ALIGNMENT);

    // alignment slots in one bus word
    localparam int AXI_SLOTS = AXI_WIDTH / PACKET_ALIGNMENT;

    // index of a slot inside one word
    localparam int SLOT_OFF_WIDTH = $clog2(AXI_SLOTS);

    // every unit starts with its length in bits
    localparam int HDR_LEN_WIDTH = 16;

    // unit length in slots, i.e. the header with the low zero bits dropped
    typedef logic [HDR_LEN_WIDTH-ALIGN_BITS-1:0] slice_len_t;

    // one word-wide slice from the slicer to the assembler
    typedef struct packed {
        // unit length in bits
        // only meaningful on the first slice of a unit
        logic [HDR_LEN_WIDTH-1:0] len;
        // slot-aligned data, header sits in the low bits on a first slice
        logic [AXI_WIDTH-1:0]     data;
    } slice_t;

    // high half of the shifting buffer as seen by the slicer
    typedef struct packed {
        // high half holds a word
        logic                 full;
        logic [AXI_WIDTH-1:0] data;
    } intake_t;

endpackage

`default_nettype wire

/* design/trace_word_intake.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_word_intake (
    input  wire                                   clk,
    input  wire                                   sync_rst_n,
    input  wire [replay_trace_pkg::AXI_WIDTH-1:0] in_data,
    input  wire                                   in_empty,
    input  wire                                   out_almfull,
    input  wire [63:0]                            replay_bits,
    input  wire                                   hi_lo_shift,
    output logic                                  in_rd_en,
    output replay_trace_pkg::intake_t             hi
);
    import replay_trace_pkg::*;

    // bits that index inside one word, and the word counter width left over
    localparam int WORD_BITS = $clog2(AXI_WIDTH);
    localparam int WORD_CNT_WIDTH = 64 - WORD_BITS;

    typedef enum logic {HI_EMPTY, HI_FULL} hi_state_t;

    hi_state_t                 hi_state;
    hi_state_t                 hi_state_next;
    logic [AXI_WIDTH-1:0]      hi_word;
    logic [63:0]               replay_bits_round;
    logic [WORD_CNT_WIDTH-1:0] words_total;
    logic [WORD_CNT_WIDTH-1:0] words_loaded;
    logic                      hi_free;
    logic                      pad_load;
    logic                      hi_load;

    // high half can take a word when empty or when it moves down this cycle
    assign hi_free = (hi_state == HI_EMPTY) || hi_lo_shift;

    // output side almost full only throttles reads
    assign in_rd_en = !in_empty && !out_almfull && hi_free;

    // words needed to hold the whole trace, rounded up
    assign replay_bits_round = replay_bits + 64'(AXI_WIDTH - 1);
    assign words_total = replay_bits_round[63:WORD_BITS];

    // once every trace word is in, push one zero word behind it
    // so the last unit in the low half gets a full high half to slice against
    // words_loaded moves past words_total after this, so it fires once
    assign pad_load = hi_free && !in_rd_en && (words_total != '0) &&
                      (words_loaded == words_total);

    assign hi_load = in_rd_en || pad_load;

    // high half state
    always_comb begin
        case (hi_state)
            HI_EMPTY: begin
                hi_state_next = hi_load ? HI_FULL : HI_EMPTY;
            end
            HI_FULL: begin
                // shift without refill empties it, anything else holds or flows
                if (hi_lo_shift && !hi_load) begin
                    hi_state_next = HI_EMPTY;
                end else begin
                    hi_state_next = HI_FULL;
                end
            end
            default: begin
                hi_state_next = HI_EMPTY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_state <= HI_EMPTY;
            words_loaded <= '0;
        end else begin
            hi_state <= hi_state_next;
            // the pad counts too
            if (hi_load) begin
                words_loaded <= words_loaded + 1'b1;
            end
        end
    end

    // word register, fifo data wins over the pad
    always_ff @(posedge clk) begin
        if (in_rd_en) begin
            hi_word <= in_data;
        end else if (pad_load) begin
            hi_word <= '0;
        end
    end

    assign hi.full = (hi_state == HI_FULL);
    assign hi.data = hi_word;

endmodule

`default_nettype wire

/* design/trace_unit_slicer.sv */
`timescale 1ns/1ps
`default_nettype none

module trace_unit_slicer (
    input  wire                       clk,
    input  wire                       sync_rst_n,
    input  wire replay_trace_pkg::intake_t hi,
    input  wire [63:0]                replay_bits,
    output logic                      hi_lo_shift,
    output replay_trace_pkg::slice_t  slice,
    output logic                      slice_valid
);
    import replay_trace_pkg::*;

    // slot counter covers the whole 64-bit replay length
    localparam int SLOT_CNT_WIDTH = 64 - ALIGN_BITS;
    // room for remaining length plus offset without overflow
    localparam int REACH_WIDTH = $bits(slice_len_t) + 1;

    typedef enum logic [1:0] {LO_EMPTY, LO_HEADER, LO_BODY} lo_state_t;

    lo_state_t                          lo_state;
    lo_state_t                          lo_state_next;
    logic [AXI_WIDTH-1:0]               lo_word;
    logic [2*AXI_WIDTH-1:0]             shift_buf;
    logic [SLOT_OFF_WIDTH-1:0]          lo_off;
    logic [SLOT_OFF_WIDTH-1:0]          lo_off_next;
    logic [SLOT_OFF_WIDTH+ALIGN_BITS-1:0] bit_off;
    logic [AXI_WIDTH-1:0]               win_data;
    slice_len_t                         remain_len;
    slice_len_t                         remain_reg;
    slice_len_t                         slot_step;
    logic [REACH_WIDTH-1:0]             reach;
    logic                               lo_out;
    logic                               lo_exhaust;
    logic                               lo_satisfied;
    logic [SLOT_CNT_WIDTH-1:0]          slot_total;
    logic [SLOT_CNT_WIDTH-1:0]          slot_cnt;
    logic                               replay_done;

    // high half above low half, read window starts at the slot offset
    assign shift_buf = {hi.data, lo_word};
    assign bit_off = {lo_off, {ALIGN_BITS{1'b0}}};
    assign win_data = shift_buf[bit_off +: AXI_WIDTH];

    // remaining slots of the current unit
    // header state decodes it straight from the window
    always_comb begin
        case (lo_state)
            LO_HEADER: remain_len = win_data[ALIGN_BITS +: $bits(slice_len_t)];
            LO_BODY:   remain_len = remain_reg;
            default:   remain_len = '0;
        endcase
    end

    // slice only when data is continuous across both halves
    assign lo_out = hi.full && (lo_state != LO_EMPTY);

    // this slice consumes everything left in the low half
    assign reach = REACH_WIDTH'(remain_len) + REACH_WIDTH'(lo_off);
    assign lo_exhaust = reach >= REACH_WIDTH'(AXI_SLOTS);

    // rest of the unit fits in this slice
    assign lo_satisfied = remain_len <= slice_len_t'(AXI_SLOTS);

    // load an empty low half, or refill once it is used up
    assign hi_lo_shift = hi.full && ((lo_state == LO_EMPTY) || (lo_out && lo_exhaust));

    always_comb begin
        lo_state_next = lo_state;
        lo_off_next = lo_off;
        case (lo_state)
            LO_EMPTY: begin
                lo_off_next = '0;
                if (hi_lo_shift) begin
                    lo_state_next = LO_HEADER;
                end
            end
            LO_HEADER, LO_BODY: begin
                if (lo_out) begin
                    if (lo_satisfied) begin
                        // unit ends here, next slot is a header
                        // offset wraps into the new low half on a shift
                        lo_state_next = LO_HEADER;
                        lo_off_next = lo_off + remain_len[SLOT_OFF_WIDTH-1:0];
                    end else begin
                        // a whole word went out and the rest follows at the same offset
                        lo_state_next = LO_BODY;
                    end
                end
            end
            default: begin
                lo_state_next = LO_EMPTY;
                lo_off_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_state <= LO_EMPTY;
            lo_off <= '0;
        end else begin
            lo_state <= lo_state_next;
            lo_off <= lo_off_next;
        end
    end

    // low half data and body length carry
    always_ff @(posedge clk) begin
        if (hi_lo_shift) begin
            lo_word <= hi.data;
        end
        if (lo_out && !lo_satisfied) begin
            remain_reg <= remain_len - slice_len_t'(AXI_SLOTS);
        end
    end

    // replay progress in slots, padding after the trace is not forwarded
    assign slot_total = replay_bits[63:ALIGN_BITS];
    assign replay_done = (slot_cnt == slot_total);
    assign slot_step = lo_satisfied ? remain_len : slice_len_t'(AXI_SLOTS);

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            slot_cnt <= '0;
            slice_valid <= 1'b0;
        end else begin
            if (lo_out && !replay_done) begin
                slot_cnt <= slot_cnt + SLOT_CNT_WIDTH'(slot_step);
            end
            slice_valid <= lo_out && !replay_done;
        end
    end

    // registered slice toward the assembler
    // length is back in bits, used only on a first slice
    always_ff @(posedge clk) begin
        slice.data <= win_data;
        slice.len <= {remain_len, {ALIGN_BITS{1'b0}}};
    end

endmodule

`default_nettype wire

/* design/unit_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module unit_assembler #(
    parameter int UNIT_WIDTH = 256
) (
    input  wire                           clk,
    input  wire                           sync_rst_n,
    input  wire replay_trace_pkg::slice_t slice,
    input  wire                           slice_valid,
    output logic [UNIT_WIDTH-1:0]         out_data,
    output logic                          out_valid
);
    import replay_trace_pkg::*;

    // bus words needed for the widest unit
    localparam int NUM_WORDS = (UNIT_WIDTH - 1) / AXI_WIDTH + 1;
    localparam int WORD_BITS = $clog2(AXI_WIDTH);
    localparam int CNT_WIDTH = $clog2(NUM_WORDS + 1);
    // bits gathered so far, one wider than the header length
    localparam int FILL_WIDTH = HDR_LEN_WIDTH + 1;

    typedef enum logic [1:0] {ASM_WAIT_HDR, ASM_WAIT_BODY, ASM_DONE} asm_state_t;

    asm_state_t                           asm_state;
    asm_state_t                           asm_state_next;
    logic [NUM_WORDS-1:0][AXI_WIDTH-1:0]  unit_buf;
    logic [NUM_WORDS*AXI_WIDTH-1:0]       unit_flat;
    logic [CNT_WIDTH-1:0]                 word_cnt;
    logic [HDR_LEN_WIDTH-1:0]             unit_len;
    logic [FILL_WIDTH-1:0]                fill_bits;
    logic                                 single_slice;
    logic                                 unit_done;

    // header slice carries the whole unit
    assign single_slice = slice.len <= HDR_LEN_WIDTH'(AXI_WIDTH);

    // bits held once the incoming body slice is added
    assign fill_bits = (FILL_WIDTH'(word_cnt) + 1'b1) << WORD_BITS;
    assign unit_done = FILL_WIDTH'(unit_len) <= fill_bits;

    always_comb begin
        case (asm_state)
            ASM_WAIT_HDR: begin
                if (slice_valid) begin
                    asm_state_next = single_slice ? ASM_DONE : ASM_WAIT_BODY;
                end else begin
                    asm_state_next = ASM_WAIT_HDR;
                end
            end
            ASM_WAIT_BODY: begin
                if (slice_valid && unit_done) begin
                    asm_state_next = ASM_DONE;
                end else begin
                    asm_state_next = ASM_WAIT_BODY;
                end
            end
            ASM_DONE: begin
                // output goes out this cycle, a new header may land at once
                if (slice_valid) begin
                    asm_state_next = single_slice ? ASM_DONE : ASM_WAIT_BODY;
                end else begin
                    asm_state_next = ASM_WAIT_HDR;
                end
            end
            default: begin
                asm_state_next = ASM_WAIT_HDR;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= ASM_WAIT_HDR;
            word_cnt <= '0;
            unit_len <= '0;
        end else begin
            asm_state <= asm_state_next;
            if (slice_valid) begin
                if (asm_state == ASM_WAIT_BODY) begin
                    word_cnt <= word_cnt + 1'b1;
                end else begin
                    // any slice outside body collection starts a unit
                    unit_len <= slice.len;
                    word_cnt <= CNT_WIDTH'(1);
                end
            end
        end
    end

    // unit words, upper words past the length keep stale data
    always_ff @(posedge clk) begin
        if (slice_valid) begin
            if (asm_state == ASM_WAIT_BODY) begin
                unit_buf[word_cnt] <= slice.data;
            end else begin
                unit_buf[0] <= slice.data;
            end
        end
    end

    assign unit_flat = unit_buf;
    assign out_data = unit_flat[UNIT_WIDTH-1:0];
    assign out_valid = (asm_state == ASM_DONE);

endmodule

`default_nettype wire

/* design/replay_trace_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module replay_trace_parser #(
    parameter int UNIT_WIDTH = 256
) (
    input  wire                                   clk,
    input  wire                                   sync_rst_n,
    // input FIFO
    input  wire [replay_trace_pkg::AXI_WIDTH-1:0] in_data,
    input  wire                                   in_empty,
    output logic                                  in_rd_en,
    // output FIFO
    input  wire                                   out_almfull,
    output logic [UNIT_WIDTH-1:0]                 out_data,
    output logic                                  out_valid,
    // total trace length in bits, held for the run
    input  wire [63:0]                            replay_bits
);
    import replay_trace_pkg::*;

    intake_t hi;
    logic    hi_lo_shift;
    slice_t  slice;
    logic    slice_valid;

    // fifo reads and high half of the buffer
    trace_word_intake u_intake (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .out_almfull (out_almfull),
        .replay_bits (replay_bits),
        .hi_lo_shift (hi_lo_shift),
        .in_rd_en    (in_rd_en),
        .hi          (hi)
    );

    // low half, header decode and slicing
    trace_unit_slicer u_slicer (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .hi          (hi),
        .replay_bits (replay_bits),
        .hi_lo_shift (hi_lo_shift),
        .slice       (slice),
        .slice_valid (slice_valid)
    );

    // gathers slices into whole units
    unit_assembler #(
        .UNIT_WIDTH (UNIT_WIDTH)
    ) u_assembler (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .slice       (slice),
        .slice_valid (slice_valid),
        .out_data    (out_data),
        .out_valid   (out_valid)
    );

endmodule

`default_nettype wire

/* test/tb_replay_trace_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_replay_trace_parser;
    import replay_trace_pkg::*;

    localparam int UNIT_WIDTH = 256;
    localparam int CLK_HALF = 10;
    localparam int NUM_TESTS = 9;
    localparam int MAX_UNITS = 64;
    localparam int MAX_WORDS = 512;
    localparam int WORD_BYTES = AXI_WIDTH / 8;
    // bus words taken by one unit of the widest length
    localparam int WORDS_PER_UNIT = UNIT_WIDTH / AXI_WIDTH;

    // one row of the scenario table
    typedef struct packed {
        logic [7:0]  num_units;
        // zero means a random length for every unit
        logic [15:0] unit_len;
        // 0 never high, 1 periodic, 2 high for the first 40 cycles
        logic [1:0]  almfull_mode;
        // units expected on out_valid
        logic [7:0]  exp_outputs;
    } scenario_t;

    logic                  clk;
    logic                  sync_rst_n;
    logic [AXI_WIDTH-1:0]  in_data;
    logic                  in_empty;
    logic                  in_rd_en;
    logic                  out_almfull;
    logic [UNIT_WIDTH-1:0] out_data;
    logic                  out_valid;
    logic [63:0]           replay_bits;

    // input FIFO contents and expected units of the running test
    logic [AXI_WIDTH-1:0]  fifo_mem [0:MAX_WORDS-1];
    logic [UNIT_WIDTH-1:0] exp_unit [0:MAX_UNITS-1];
    logic [UNIT_WIDTH-1:0] exp_mask [0:MAX_UNITS-1];
    int                    fifo_words;
    int                    exp_count;
    int                    rd_ptr = 0;
    int                    rx_count = 0;
    int                    mon_errors = 0;
    int                    mon_checks = 0;
    int                    main_errors = 0;
    int                    tests_failed = 0;
    int                    cyc;
    integer                seed = 68790;
    scenario_t             cur;

    replay_trace_parser #(
        .UNIT_WIDTH (UNIT_WIDTH)
    ) UUT (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .in_rd_en    (in_rd_en),
        .out_almfull (out_almfull),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .replay_bits (replay_bits)
    );

    initial clk = 1'b0;
    always #CLK_HALF clk = ~clk;

    // scenario table
    // columns are units, unit length in bits (0 random), almost-full mode and outputs
    function automatic scenario_t scenario_at(input int idx);
        case (idx)
            // short 24 and 40 bit units that straddle word boundaries
            0: return {8'd6, 16'd24, 2'd0, 8'd6};
            1: return {8'd7, 16'd40, 2'd0, 8'd7};
            // just over one word and then the widest unit
            2: return {8'd5, 16'd72, 2'd0, 8'd5};
            3: return {8'd4, 16'd256, 2'd0, 8'd4};
            // traces that end exactly on a word boundary
            4: return {8'd8, 16'd64, 2'd0, 8'd8};
            5: return {8'd3, 16'd128, 2'd0, 8'd3};
            // back-pressure from the output side
            6: return {8'd6, 16'd200, 2'd1, 8'd6};
            7: return {8'd12, 16'd0, 2'd2, 8'd12};
            default: return {8'd60, 16'd0, 2'd1, 8'd60};
        endcase
    endfunction

    // input FIFO pops and output checks sampled on the rising edge
    always @(posedge clk) begin
        if (!sync_rst_n) begin
            rd_ptr = 0;
            rx_count = 0;
        end else begin
            if (in_rd_en && in_empty) begin
                $display("error: in_rd_en expected %h got %h while in_empty is high",
                         1'b0, in_rd_en);
                mon_errors++;
            end
            if (in_rd_en && out_almfull) begin
                $display("error: in_rd_en expected %h got %h while out_almfull is high",
                         1'b0, in_rd_en);
                mon_errors++;
            end
            if (in_rd_en) begin
                rd_ptr++;
            end
            if (out_valid) begin
                if (rx_count >= exp_count) begin
                    $display("error: extra unit on out_data after %0d expected units",
                             exp_count);
                    mon_errors++;
                end else begin
                    mon_checks++;
                    // bits above the unit length belong to the next unit
                    if ((out_data & exp_mask[rx_count]) !== exp_unit[rx_count]) begin
                        $display("error: out_data unit %0d expected %h got %h", rx_count,
                                 exp_unit[rx_count], out_data & exp_mask[rx_count]);
                        mon_errors++;
                    end
                end
                rx_count++;
            end
        end
    end

    // FIFO level and back-pressure for the coming cycle
    task automatic drive_inputs();
        in_empty = (rd_ptr >= fifo_words);
        in_data = (rd_ptr < fifo_words) ? fifo_mem[rd_ptr] : '0;
        case (cur.almfull_mode)
            2'd1: out_almfull = (cyc % 7) < 3;
            2'd2: out_almfull = cyc < 40;
            default: out_almfull = 1'b0;
        endcase
        cyc++;
    endtask

    task automatic hold_reset();
        @(negedge clk);
        sync_rst_n = 1'b0;
        in_empty = 1'b1;
        in_data = '0;
        out_almfull = 1'b0;
    endtask

    // three rising edges in reset before the inputs follow the FIFO model
    task automatic release_reset();
        repeat (3) @(negedge clk);
        sync_rst_n = 1'b1;
        cyc = 0;
        drive_inputs();
    endtask

    // byte-packed trace lsb first with each unit led by its length in bits
    task automatic build_trace(input scenario_t s);
        logic [UNIT_WIDTH-1:0] unit;
        logic [31:0]           rnd;
        int                    len;
        int                    byte_pos;
        for (int w = 0; w < MAX_WORDS; w++) begin
            fifo_mem[w] = '0;
        end
        byte_pos = 0;
        for (int u = 0; u < int'(s.num_units); u++) begin
            if (s.unit_len != 16'd0) begin
                len = int'(s.unit_len);
            end else begin
                rnd = $random(seed);
                // 16 to UNIT_WIDTH in whole bytes
                len = 16 + 8 * int'(rnd % 32'd31);
            end
            unit = '0;
            unit[15:0] = len[15:0];
            for (int b = 2; b < len / 8; b++) begin
                rnd = $random(seed);
                unit[b*8 +: 8] = rnd[7:0];
            end
            exp_unit[u] = unit;
            exp_mask[u] = {UNIT_WIDTH{1'b1}} >> (UNIT_WIDTH - len);
            for (int b = 0; b < len / 8; b++) begin
                fifo_mem[byte_pos / WORD_BYTES][(byte_pos % WORD_BYTES) * 8 +: 8] =
                    unit[b*8 +: 8];
                byte_pos++;
            end
        end
        exp_count = int'(s.num_units);
        fifo_words = (byte_pos + WORD_BYTES - 1) / WORD_BYTES;
        replay_bits = 64'(byte_pos) * 64'd8;
    endtask

    // nothing must move with an empty FIFO
    task automatic check_idle();
        int errors_before;
        errors_before = main_errors + mon_errors;
        cur = '0;
        hold_reset();
        fifo_words = 0;
        exp_count = 0;
        replay_bits = '0;
        release_reset();
        repeat (8) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("error: out_valid expected %h got %h when idle", 1'b0, out_valid);
                main_errors++;
            end
            if (in_rd_en !== 1'b0) begin
                $display("error: in_rd_en expected %h got %h when idle", 1'b0, in_rd_en);
                main_errors++;
            end
            drive_inputs();
        end
        if (main_errors + mon_errors != errors_before) begin
            tests_failed++;
        end
        $display("test idle: %0d errors", main_errors + mon_errors - errors_before);
    endtask

    task automatic run_test(input int idx);
        int errors_before;
        errors_before = main_errors + mon_errors;
        cur = scenario_at(idx);
        hold_reset();
        build_trace(cur);
        release_reset();
        while (rx_count < exp_count) begin
            @(negedge clk);
            drive_inputs();
        end
        // leave room for a stray unit from the flush word
        repeat (30) begin
            @(negedge clk);
            drive_inputs();
        end
        if (rx_count != int'(cur.exp_outputs)) begin
            $display("error: out_valid count expected %h got %h", cur.exp_outputs, rx_count);
            main_errors++;
        end
        if (rd_ptr != fifo_words) begin
            $display("trace words left unread: %0d of %0d taken", rd_ptr, fifo_words);
            main_errors++;
        end
        if (main_errors + mon_errors != errors_before) begin
            tests_failed++;
        end
        $display("test %0d: %0d units, %0d words, %0d errors", idx, exp_count, fifo_words,
                 main_errors + mon_errors - errors_before);
    endtask

    // run limit from the worst-case trace length of every table row
    initial begin : watchdog
        int        limit_cycles;
        scenario_t s;
        limit_cycles = 1000;
        for (int i = 0; i < NUM_TESTS; i++) begin
            s = scenario_at(i);
            limit_cycles += (int'(s.num_units) * WORDS_PER_UNIT + 1) * 20 + 100;
        end
        #(limit_cycles * 2 * CLK_HALF);
        $display("timeout: the parser stopped delivering units before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        sync_rst_n = 1'b0;
        in_data = '0;
        in_empty = 1'b1;
        out_almfull = 1'b0;
        replay_bits = '0;
        fifo_words = 0;
        exp_count = 0;
        cyc = 0;
        cur = '0;
        check_idle();
        for (int i = 0; i < NUM_TESTS; i++) begin
            run_test(i);
        end
        $display("summary: %0d tests, %0d failed, %0d units checked, %0d errors",
                 NUM_TESTS + 1, tests_failed, mon_checks, main_errors + mon_errors);
        if (tests_failed == 0 && main_errors + mon_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
design/replay_trace_pkg.sv
design/trace_word_intake.sv
design/trace_unit_slicer.sv
design/unit_assembler.sv
design/replay_trace_parser.sv
test/tb_replay_trace_parser.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -j 0 \
    --top-module tb_replay_trace_parser \
    -f filelist.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -qx "TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
